// ==== adv7513_ctrl.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module adv7513_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hdmi_int,
    input  logic                      vsync,
    input  logic                      vsync_on_polarity,
    input  logic [`ADV_REG_W-1:0]     adv_reg_17,
    input  logic [`ADV_REG_W-1:0]     adv_reg_3b,
    input  logic [`ADV_REG_W-1:0]     adv_reg_3c,
    output logic [`ADV_REG_W-1:0]     i2c_reg_addr,
    output logic [`ADV_REG_W-1:0]     i2c_value,
    output logic                      i2c_is_read,
    output logic                      i2c_enable,
    input  logic                      i2c_done,
    input  logic [`ADV_REG_W-1:0]     i2c_data,
    input  logic                      i2c_ack_error,
    output logic                      ready,
    output logic [`ADV_REG_W-1:0]     chip_revision,
    output logic [`ADV_REG_W-1:0]     pll_status,
    output logic [`ADV_REG_W-1:0]     vic_detected,
    output logic [`ADV_ERR_CNT_W-1:0] pll_error_count
);

    adv_pkg::reg_write_t   entry;
    logic [`ADV_IDX_W-1:0] index;
    logic                  init_req;
    logic [`ADV_REG_W-1:0] init_reg_addr;
    logic [`ADV_REG_W-1:0] init_value;
    logic                  init_is_read;
    logic                  init_done;
    logic                  init_ack_error;
    logic [`ADV_REG_W-1:0] init_rdata;
    logic                  poll_req;
    logic [`ADV_REG_W-1:0] poll_reg_addr;
    logic                  poll_is_read;
    logic                  poll_done;
    logic [`ADV_REG_W-1:0] poll_rdata;

    adv_init_rom u_rom (
        .index      (index),
        .adv_reg_17 (adv_reg_17),
        .adv_reg_3b (adv_reg_3b),
        .adv_reg_3c (adv_reg_3c),
        .entry      (entry)
    );

    adv_init_seq u_seq (
        .clk       (clk),
        .reset     (reset),
        .hdmi_int  (hdmi_int),
        .entry     (entry),
        .index     (index),
        .req       (init_req),
        .reg_addr  (init_reg_addr),
        .value     (init_value),
        .is_read   (init_is_read),
        .done      (init_done),
        .rdata     (init_rdata),
        .ack_error (init_ack_error),
        .ready     (ready)
    );

    adv_status_poll u_poll (
        .clk               (clk),
        .reset             (reset),
        .ready             (ready),
        .vsync             (vsync),
        .vsync_on_polarity (vsync_on_polarity),
        .req               (poll_req),
        .reg_addr          (poll_reg_addr),
        .is_read           (poll_is_read),
        .done              (poll_done),
        .rdata             (poll_rdata),
        .chip_revision     (chip_revision),
        .pll_status        (pll_status),
        .vic_detected      (vic_detected),
        .pll_error_count   (pll_error_count)
    );

    i2c_cmd_arbiter u_arb (
        .clk            (clk),
        .reset          (reset),
        .init_req       (init_req),
        .init_reg_addr  (init_reg_addr),
        .init_value     (init_value),
        .init_is_read   (init_is_read),
        .init_done      (init_done),
        .init_ack_error (init_ack_error),
        .poll_req       (poll_req),
        .poll_reg_addr  (poll_reg_addr),
        .poll_is_read   (poll_is_read),
        .poll_done      (poll_done),
        .poll_rdata     (poll_rdata),
        .rdata_out      (init_rdata),
        .i2c_reg_addr   (i2c_reg_addr),
        .i2c_value      (i2c_value),
        .i2c_is_read    (i2c_is_read),
        .i2c_enable     (i2c_enable),
        .i2c_done       (i2c_done),
        .i2c_data       (i2c_data),
        .i2c_ack_error  (i2c_ack_error)
    );

endmodule

// ==== adv_defs.svh ====
`ifndef ADV_DEFS_SVH
`define ADV_DEFS_SVH

// register address and data width of the transmitter
`define ADV_REG_W 8

// bootstrap writes, then bootstrap and setup writes together
`define ADV_BOOT_LEN 11
`define ADV_INIT_LEN 27

// wide enough to hold ADV_INIT_LEN, which marks the PLL check step
`define ADV_IDX_W 5

// status registers
`define ADV_REG_PLL 8'h9E
`define ADV_REG_REV 8'h00
`define ADV_REG_VIC 8'h3E

// lock flag in the PLL status register
`define ADV_PLL_LOCK_BIT 4

// PLL error counter width
`define ADV_ERR_CNT_W 8

`endif

// ==== adv_init_rom.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module adv_init_rom (
    input  logic [`ADV_IDX_W-1:0] index,
    input  logic [`ADV_REG_W-1:0] adv_reg_17,
    input  logic [`ADV_REG_W-1:0] adv_reg_3b,
    input  logic [`ADV_REG_W-1:0] adv_reg_3c,
    output adv_pkg::reg_write_t   entry
);

    always_comb begin
        case (index)
            // bootstrap, power up and fixed registers
            5'd0:  entry = {8'h41, 8'h10};
            5'd1:  entry = {8'h98, 8'h03};
            5'd2:  entry = {8'h9A, 8'hE0};
            5'd3:  entry = {8'h9C, 8'h30};
            5'd4:  entry = {8'h9D, 8'h01};
            5'd5:  entry = {8'hA2, 8'hA4};
            5'd6:  entry = {8'hA3, 8'hA4};
            5'd7:  entry = {8'hE0, 8'hD0};
            5'd8:  entry = {8'hF9, 8'h00};
            // enable HPD and monitor sense interrupts
            5'd9:  entry = {8'h94, 8'hC0};
            // clear pending interrupt flags
            5'd10: entry = {8'h96, 8'hC0};

            // setup, 44.1kHz I2S and 24 bit RGB 4:4:4 input
            5'd11: entry = {8'h15, 8'h00};
            // sync polarity and aspect ratio come from the video mode
            5'd12: entry = {8'h17, adv_reg_17};
            // 4:4:4 output, 8 bit color depth
            5'd13: entry = {8'h16, 8'h30};
            5'd14: entry = {8'h55, 8'h00};
            // CSC off
            5'd15: entry = {8'h18, 8'h46};
            // HDMI mode, no HDCP
            5'd16: entry = {8'hAF, 8'h06};
            5'd17: entry = {8'hBA, 8'h60};
            // automatic CTS, I2S audio, 128xfs
            5'd18: entry = {8'h0A, 8'h00};
            // N value 0x1880 for 44.1kHz
            5'd19: entry = {8'h01, 8'h00};
            5'd20: entry = {8'h02, 8'h18};
            5'd21: entry = {8'h03, 8'h80};
            5'd22: entry = {8'h0B, 8'h0E};
            // I2S0 only, right justified, 16 bit samples
            5'd23: entry = {8'h0C, 8'h05};
            5'd24: entry = {8'h0D, 8'h10};
            // pixel repetition and VIC from the video mode
            5'd25: entry = {8'h3B, adv_reg_3b};
            5'd26: entry = {8'h3C, adv_reg_3c};

            // past the list the sequencer reads PLL status instead
            default: entry = {`ADV_REG_PLL, 8'h00};
        endcase
    end

endmodule

// ==== adv_init_seq.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module adv_init_seq (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hdmi_int,
    input  adv_pkg::reg_write_t   entry,
    output logic [`ADV_IDX_W-1:0] index,
    output logic                  req,
    output logic [`ADV_REG_W-1:0] reg_addr,
    output logic [`ADV_REG_W-1:0] value,
    output logic                  is_read,
    input  logic                  done,
    input  logic [`ADV_REG_W-1:0] rdata,
    input  logic                  ack_error,
    output logic                  ready
);

    localparam logic [`ADV_IDX_W-1:0] pll_index = `ADV_INIT_LEN;

    adv_pkg::init_state_t state;
    logic hdmi_int_prev;
    logic int_fall;
    logic int_pending;
    logic waiting;
    logic restart;

    // hdmi_int is active low, the chip pulls it down on a hotplug event
    assign int_fall = hdmi_int_prev & ~hdmi_int;

    assign waiting = (state == adv_pkg::init_wait_write) || (state == adv_pkg::init_wait_pll);

    // a latched interrupt takes effect once the running transfer is done
    assign restart = (waiting && done && (int_pending || int_fall))
                  || (state == adv_pkg::init_ready && int_fall);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= adv_pkg::init_idle;
            index         <= '0;
            req           <= 1'b0;
            ready         <= 1'b0;
            hdmi_int_prev <= 1'b1;
            int_pending   <= 1'b0;
        end else begin
            hdmi_int_prev <= hdmi_int;

            if (restart) begin
                int_pending <= 1'b0;
            end else if (int_fall) begin
                int_pending <= 1'b1;
            end

            case (state)
                adv_pkg::init_idle: begin
                    index <= '0;
                    state <= adv_pkg::init_issue;
                end

                adv_pkg::init_issue: begin
                    req   <= 1'b1;
                    state <= (index == pll_index) ? adv_pkg::init_wait_pll
                                                  : adv_pkg::init_wait_write;
                end

                adv_pkg::init_wait_write: begin
                    if (done) begin
                        req   <= 1'b0;
                        state <= adv_pkg::init_issue;
                        if (restart) begin
                            index <= '0;
                        end else if (!ack_error) begin
                            index <= index + 1'b1;
                        end
                    end
                end

                adv_pkg::init_wait_pll: begin
                    if (done) begin
                        req <= 1'b0;
                        if (restart || (!ack_error && !rdata[`ADV_PLL_LOCK_BIT])) begin
                            // pll not locked yet, run the whole list again
                            index <= '0;
                            state <= adv_pkg::init_issue;
                        end else if (ack_error) begin
                            state <= adv_pkg::init_issue;
                        end else begin
                            ready <= 1'b1;
                            state <= adv_pkg::init_ready;
                        end
                    end
                end

                adv_pkg::init_ready: begin
                    if (int_fall) begin
                        ready <= 1'b0;
                        index <= '0;
                        state <= adv_pkg::init_issue;
                    end
                end

                default: state <= adv_pkg::init_idle;
            endcase
        end
    end

    // transfer fields, held while req is up
    always_ff @(posedge clk) begin
        if (state == adv_pkg::init_issue) begin
            if (index == pll_index) begin
                reg_addr <= `ADV_REG_PLL;
                value    <= '0;
                is_read  <= 1'b1;
            end else begin
                reg_addr <= entry.addr;
                value    <= entry.value;
                is_read  <= 1'b0;
            end
        end
    end

endmodule

// ==== adv_pkg.sv ====
`include "adv_defs.svh"

package adv_pkg;

    // one register write of the setup list
    typedef struct packed {
        logic [`ADV_REG_W-1:0] addr;
        logic [`ADV_REG_W-1:0] value;
    } reg_write_t;

    // init sequencer states
    typedef enum logic [2:0] {
        init_idle,
        init_issue,
        init_wait_write,
        init_wait_pll,
        init_ready
    } init_state_t;

    // status poller states
    typedef enum logic [1:0] {
        poll_idle,
        poll_issue,
        poll_wait
    } poll_state_t;

endpackage

// ==== adv_status_poll.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module adv_status_poll (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ready,
    input  logic                      vsync,
    input  logic                      vsync_on_polarity,
    output logic                      req,
    output logic [`ADV_REG_W-1:0]     reg_addr,
    output logic                      is_read,
    input  logic                      done,
    input  logic [`ADV_REG_W-1:0]     rdata,
    output logic [`ADV_REG_W-1:0]     chip_revision,
    output logic [`ADV_REG_W-1:0]     pll_status,
    output logic [`ADV_REG_W-1:0]     vic_detected,
    output logic [`ADV_ERR_CNT_W-1:0] pll_error_count
);

    adv_pkg::poll_state_t state;
    logic       vsync_reg;
    logic       vsync_trail;
    logic [1:0] step;

    // end of the sync pulse, whatever its polarity
    assign vsync_trail = (vsync_reg == vsync_on_polarity) && (vsync != vsync_on_polarity);

    // the poller only reads
    assign is_read = 1'b1;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state           <= adv_pkg::poll_idle;
            vsync_reg       <= 1'b0;
            step            <= 2'd0;
            req             <= 1'b0;
            chip_revision   <= '0;
            pll_status      <= '0;
            vic_detected    <= '0;
            pll_error_count <= '0;
        end else begin
            vsync_reg <= vsync;

            case (state)
                adv_pkg::poll_idle: begin
                    // edges seen while a poll runs are simply lost
                    if (ready && vsync_trail) begin
                        step  <= 2'd0;
                        state <= adv_pkg::poll_issue;
                    end
                end

                adv_pkg::poll_issue: begin
                    req   <= 1'b1;
                    state <= adv_pkg::poll_wait;
                end

                adv_pkg::poll_wait: begin
                    if (done) begin
                        req <= 1'b0;
                        case (step)
                            2'd0: chip_revision <= rdata;
                            2'd1: begin
                                pll_status <= rdata;
                                if (!rdata[`ADV_PLL_LOCK_BIT]) begin
                                    pll_error_count <= pll_error_count + 1'b1;
                                end
                            end
                            default: vic_detected <= rdata;
                        endcase
                        if (step == 2'd2) begin
                            state <= adv_pkg::poll_idle;
                        end else begin
                            step  <= step + 1'b1;
                            state <= adv_pkg::poll_issue;
                        end
                    end
                end

                default: state <= adv_pkg::poll_idle;
            endcase
        end
    end

    // revision, pll status, detected vic
    always_ff @(posedge clk) begin
        if (state == adv_pkg::poll_issue) begin
            case (step)
                2'd0:    reg_addr <= `ADV_REG_REV;
                2'd1:    reg_addr <= `ADV_REG_PLL;
                default: reg_addr <= `ADV_REG_VIC;
            endcase
        end
    end

endmodule

// ==== build.f ====
+incdir+.
adv_pkg.sv
adv_init_rom.sv
adv_init_seq.sv
adv_status_poll.sv
i2c_cmd_arbiter.sv
adv7513_ctrl.sv
tb_i2c_model.sv
tb_adv7513_ctrl.sv

// ==== i2c_cmd_arbiter.sv ====
`timescale 1ns/1ns

module i2c_cmd_arbiter (
    input  logic       clk,
    input  logic       reset,

    input  logic       init_req,
    input  logic [7:0] init_reg_addr,
    input  logic [7:0] init_value,
    input  logic       init_is_read,
    output logic       init_done,
    output logic       init_ack_error,

    input  logic       poll_req,
    input  logic [7:0] poll_reg_addr,
    input  logic       poll_is_read,
    output logic       poll_done,
    output logic [7:0] poll_rdata,

    output logic [7:0] rdata_out,

    output logic [7:0] i2c_reg_addr,
    output logic [7:0] i2c_value,
    output logic       i2c_is_read,
    output logic       i2c_enable,
    input  logic       i2c_done,
    input  logic [7:0] i2c_data,
    input  logic       i2c_ack_error
);

    logic busy;
    logic grant_poll;

    // grant is taken when idle and kept until the engine reports done
    always_ff @(posedge clk) begin
        if (!reset) begin
            busy       <= 1'b0;
            grant_poll <= 1'b0;
            i2c_enable <= 1'b0;
        end else begin
            i2c_enable <= 1'b0;
            if (busy) begin
                if (i2c_done) begin
                    busy <= 1'b0;
                end
            end else if (init_req || poll_req) begin
                // init wins over poll
                busy       <= 1'b1;
                grant_poll <= !init_req;
                i2c_enable <= 1'b1;
            end
        end
    end

    assign i2c_reg_addr = grant_poll ? poll_reg_addr : init_reg_addr;
    assign i2c_value    = grant_poll ? 8'h00 : init_value;
    assign i2c_is_read  = grant_poll ? poll_is_read : init_is_read;

    // done and ack error go back to the granted side only
    assign init_done      = i2c_done & busy & ~grant_poll;
    assign poll_done      = i2c_done & busy & grant_poll;
    assign init_ack_error = i2c_ack_error & ~grant_poll;

    assign rdata_out  = i2c_data;
    assign poll_rdata = i2c_data;

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_adv7513_ctrl -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q '^>>> PASS$' sim.log \
    || { echo "simulation did not pass"; exit 1; }

// ==== tb_adv7513_ctrl.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module tb_adv7513_ctrl;

    localparam int max_latency = 8;
    // four full sequences at worst latency and handshake overhead times three
    localparam int cycle_limit = 4 * (`ADV_INIT_LEN + 1) * (max_latency + 4) * 3;
    localparam int poll_count = 3;

    logic                      clk;
    logic                      reset;
    logic                      hdmi_int;
    logic                      vsync;
    logic                      vsync_on_polarity;
    logic [`ADV_REG_W-1:0]     adv_reg_17;
    logic [`ADV_REG_W-1:0]     adv_reg_3b;
    logic [`ADV_REG_W-1:0]     adv_reg_3c;
    logic [`ADV_REG_W-1:0]     i2c_reg_addr;
    logic [`ADV_REG_W-1:0]     i2c_value;
    logic                      i2c_is_read;
    logic                      i2c_enable;
    logic                      i2c_done;
    logic [`ADV_REG_W-1:0]     i2c_data;
    logic                      i2c_ack_error;
    logic                      ready;
    logic [`ADV_REG_W-1:0]     chip_revision;
    logic [`ADV_REG_W-1:0]     pll_status;
    logic [`ADV_REG_W-1:0]     vic_detected;
    logic [`ADV_ERR_CNT_W-1:0] pll_error_count;
    logic [`ADV_REG_W-1:0]     rev_data;
    logic [`ADV_REG_W-1:0]     pll_data;
    logic [`ADV_REG_W-1:0]     vic_data;
    logic                      ack_err;
    int                        model_count;
    int                        cycles = 0;
    int                        txn_seen = 0;
    int                        exp_errors = 0;

    // {addr, value, is_read} of each init transfer with the PLL read last
    logic [16:0] init_tab [0:`ADV_INIT_LEN];
    // {revision, pll status, vic} returned and expected per poll
    logic [23:0] poll_tab [0:poll_count-1];

    adv7513_ctrl DUT (
        .clk               (clk),
        .reset             (reset),
        .hdmi_int          (hdmi_int),
        .vsync             (vsync),
        .vsync_on_polarity (vsync_on_polarity),
        .adv_reg_17        (adv_reg_17),
        .adv_reg_3b        (adv_reg_3b),
        .adv_reg_3c        (adv_reg_3c),
        .i2c_reg_addr      (i2c_reg_addr),
        .i2c_value         (i2c_value),
        .i2c_is_read       (i2c_is_read),
        .i2c_enable        (i2c_enable),
        .i2c_done          (i2c_done),
        .i2c_data          (i2c_data),
        .i2c_ack_error     (i2c_ack_error),
        .ready             (ready),
        .chip_revision     (chip_revision),
        .pll_status        (pll_status),
        .vic_detected      (vic_detected),
        .pll_error_count   (pll_error_count)
    );

    tb_i2c_model engine (
        .clk           (clk),
        .reset         (reset),
        .i2c_enable    (i2c_enable),
        .i2c_reg_addr  (i2c_reg_addr),
        .i2c_is_read   (i2c_is_read),
        .rev_data      (rev_data),
        .pll_data      (pll_data),
        .vic_data      (vic_data),
        .ack_err       (ack_err),
        .i2c_done      (i2c_done),
        .i2c_data      (i2c_data),
        .i2c_ack_error (i2c_ack_error),
        .txn_count     (model_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            stop_on_error();
        end
    end

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_txn(input logic [16:0] txn, input logic [16:0] exp);
        check_value("i2c_reg_addr", txn[16:9], exp[16:9]);
        check_value("i2c_value", txn[8:1], exp[8:1]);
        check_value("i2c_is_read", txn[0], exp[0]);
    endtask

    // waits for the next enable pulse and captures the request
    task automatic next_txn(output logic [16:0] txn);
        do begin
            @(negedge clk);
        end while (!i2c_enable);
        txn = {i2c_reg_addr, i2c_value, i2c_is_read};
        txn_seen++;
    endtask

    task automatic fill_tables();
        init_tab[0]  = {8'h41, 8'h10, 1'b0};
        init_tab[1]  = {8'h98, 8'h03, 1'b0};
        init_tab[2]  = {8'h9A, 8'hE0, 1'b0};
        init_tab[3]  = {8'h9C, 8'h30, 1'b0};
        init_tab[4]  = {8'h9D, 8'h01, 1'b0};
        init_tab[5]  = {8'hA2, 8'hA4, 1'b0};
        init_tab[6]  = {8'hA3, 8'hA4, 1'b0};
        init_tab[7]  = {8'hE0, 8'hD0, 1'b0};
        init_tab[8]  = {8'hF9, 8'h00, 1'b0};
        init_tab[9]  = {8'h94, 8'hC0, 1'b0};
        init_tab[10] = {8'h96, 8'hC0, 1'b0};
        init_tab[11] = {8'h15, 8'h00, 1'b0};
        init_tab[12] = {8'h17, adv_reg_17, 1'b0};
        init_tab[13] = {8'h16, 8'h30, 1'b0};
        init_tab[14] = {8'h55, 8'h00, 1'b0};
        init_tab[15] = {8'h18, 8'h46, 1'b0};
        init_tab[16] = {8'hAF, 8'h06, 1'b0};
        init_tab[17] = {8'hBA, 8'h60, 1'b0};
        init_tab[18] = {8'h0A, 8'h00, 1'b0};
        init_tab[19] = {8'h01, 8'h00, 1'b0};
        init_tab[20] = {8'h02, 8'h18, 1'b0};
        init_tab[21] = {8'h03, 8'h80, 1'b0};
        init_tab[22] = {8'h0B, 8'h0E, 1'b0};
        init_tab[23] = {8'h0C, 8'h05, 1'b0};
        init_tab[24] = {8'h0D, 8'h10, 1'b0};
        init_tab[25] = {8'h3B, adv_reg_3b, 1'b0};
        init_tab[26] = {8'h3C, adv_reg_3c, 1'b0};
        init_tab[`ADV_INIT_LEN] = {`ADV_REG_PLL, 8'h00, 1'b1};
        // second and third polls see the PLL unlocked
        poll_tab[0] = {8'h14, 8'h10, 8'h10};
        poll_tab[1] = {8'h14, 8'h04, 8'h04};
        poll_tab[2] = {8'h13, 8'h0C, 8'h22};
    endtask

    // unlocked_passes PLL checks fail before the locked one and err_entry is nacked once
    task automatic run_init(input int err_entry, input int unlocked_passes);
        logic [16:0] txn;
        for (int p = 0; p <= unlocked_passes; p++) begin
            for (int k = 0; k <= `ADV_INIT_LEN; k++) begin
                next_txn(txn);
                check_txn(txn, init_tab[k]);
                check_value("ready", ready, 1'b0);
                if (k == `ADV_INIT_LEN) begin
                    pll_data = (p < unlocked_passes) ? 8'h0C : 8'h1C;
                end
                if (p == 0 && k == err_entry) begin
                    ack_err = 1'b1;
                    next_txn(txn);
                    ack_err = 1'b0;
                    // same entry again after the nack
                    check_txn(txn, init_tab[k]);
                end
            end
        end
        // ready follows the done of the locked PLL read by one cycle
        do begin
            @(posedge clk);
        end while (!i2c_done);
        @(negedge clk);
        check_value("ready", ready, 1'b1);
    endtask

    task automatic run_poll(input logic [23:0] data);
        logic [16:0] txn;
        rev_data = data[23:16];
        pll_data = data[15:8];
        vic_data = data[7:0];
        check_value("ready", ready, 1'b1);
        vsync = vsync_on_polarity;
        repeat (3) @(negedge clk);
        // trailing edge of the sync pulse starts the poll
        vsync = !vsync_on_polarity;
        next_txn(txn);
        check_txn(txn, {`ADV_REG_REV, 8'h00, 1'b1});
        next_txn(txn);
        check_txn(txn, {`ADV_REG_PLL, 8'h00, 1'b1});
        next_txn(txn);
        check_txn(txn, {`ADV_REG_VIC, 8'h00, 1'b1});
        do begin
            @(posedge clk);
        end while (!i2c_done);
        @(negedge clk);
        if (!data[`ADV_PLL_LOCK_BIT + 8]) begin
            exp_errors++;
        end
        check_value("chip_revision", chip_revision, data[23:16]);
        check_value("pll_status", pll_status, data[15:8]);
        check_value("vic_detected", vic_detected, data[7:0]);
        check_value("pll_error_count", pll_error_count, exp_errors[15:0]);
    endtask

    initial begin
        reset             = 1'b0;
        hdmi_int          = 1'b1;
        vsync             = 1'b1;
        vsync_on_polarity = 1'b0;
        adv_reg_17        = 8'h02;
        adv_reg_3b        = 8'h80;
        adv_reg_3c        = 8'h10;
        rev_data          = 8'h14;
        pll_data          = 8'h00;
        vic_data          = 8'h00;
        ack_err           = 1'b0;
        fill_tables();
        repeat (4) @(negedge clk);
        reset = 1'b1;

        // first pass gets a nack on the output format write and an unlocked PLL
        run_init(13, 1);

        for (int i = 0; i < poll_count; i++) begin
            run_poll(poll_tab[i]);
        end

        // hotplug interrupt while ready
        hdmi_int = 1'b0;
        @(negedge clk);
        check_value("ready", ready, 1'b0);
        hdmi_int = 1'b1;
        run_init(-1, 0);

        repeat (4) @(negedge clk);
        check_value("txn_count", model_count[15:0], txn_seen[15:0]);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== tb_i2c_model.sv ====
`timescale 1ns/1ns
`include "adv_defs.svh"

module tb_i2c_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i2c_enable,
    input  logic [`ADV_REG_W-1:0] i2c_reg_addr,
    input  logic                  i2c_is_read,
    input  logic [`ADV_REG_W-1:0] rev_data,
    input  logic [`ADV_REG_W-1:0] pll_data,
    input  logic [`ADV_REG_W-1:0] vic_data,
    input  logic                  ack_err,
    output logic                  i2c_done,
    output logic [`ADV_REG_W-1:0] i2c_data,
    output logic                  i2c_ack_error,
    output int                    txn_count
);

    integer                seed;
    logic                  busy;
    int                    wait_cnt;
    logic [`ADV_REG_W-1:0] addr;
    logic                  is_read;

    initial begin
        seed          = 32'h8b4540ec;
        busy          = 1'b0;
        wait_cnt      = 0;
        addr          = '0;
        is_read       = 1'b0;
        i2c_done      = 1'b0;
        i2c_data      = '0;
        i2c_ack_error = 1'b0;
        txn_count     = 0;
    end

    // read data and ack errors are taken when the transfer completes
    always @(negedge clk) begin
        i2c_done      <= 1'b0;
        i2c_ack_error <= 1'b0;
        if (!reset) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 0) begin
                busy          <= 1'b0;
                i2c_done      <= 1'b1;
                i2c_ack_error <= ack_err;
                if (!is_read) begin
                    i2c_data <= '0;
                end else if (addr == `ADV_REG_REV) begin
                    i2c_data <= rev_data;
                end else if (addr == `ADV_REG_PLL) begin
                    i2c_data <= pll_data;
                end else if (addr == `ADV_REG_VIC) begin
                    i2c_data <= vic_data;
                end else begin
                    i2c_data <= '0;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (i2c_enable) begin
            // latency of 1 to 8 cycles
            busy      <= 1'b1;
            addr      <= i2c_reg_addr;
            is_read   <= i2c_is_read;
            wait_cnt  <= $unsigned($random(seed)) % 8;
            txn_count <= txn_count + 1;
        end
    end

endmodule
